// ==== sources.f ====
microroc_pkg.sv
microroc_ifs.sv
sc_reg_bank.sv
scurve_ctrl.sv
trig_counter.sv
acq_packer.sv
acq_scurve_switch.sv
usb_data_fifo.sv
microroc_daq_top.sv
tb_microroc_daq.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_microroc_daq
FILELIST = sources.f
LOG      = sim.log
PASS     = Test passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_microroc_daq.sv ====
`timescale 1ns/1ps

module tb_microroc_daq;
    import microroc_pkg::*;

    localparam int CODE_CYCLES = SETTLE_CYCLES + WINDOW_CYCLES + 8;
    localparam int STALL_CYCLES = 20 * CODE_CYCLES;
    localparam int N_ROWS = 4;

    typedef struct {
        logic mode;
        int dac_first;
        int dac_last;
        logic [31:0] chn_lo;
        logic [31:0] chn_hi;
        int thr;
        int hits;
        bit stall;
    } row_t;

    logic clk = 1'b0;
    logic rst_n;
    logic [AXIL_ADDR_W-1:0] awaddr, araddr;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic [AXIL_DATA_W-1:0] wdata;
    logic [3:0] wstrb;
    logic awready, wready, bvalid, arready, rvalid;
    logic [1:0] bresp, rresp;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [USB_DATA_W-1:0] hit_data, fifo_dout;
    logic hit_valid, trigger_n, pktend_n, fifo_rd_en, fifo_empty, usb_start_stop;
    logic [CHN_N-1:0] ctest_chn;
    logic [DAC_W-1:0] dac0, dac1, dac2;
    logic [MASK_W-1:0] discri_mask;
    logic sc_param_load;

    row_t rows [N_ROWS];
    logic [USB_DATA_W-1:0] exp_q [$];
    int errors = 0;
    int checks = 0;
    int load_cnt;
    int exp_code;
    int thr_cur = 1023;
    bit sweep_on = 0;
    logic [CHN_N-1:0] chn_cur;

    microroc_daq_top i_dut (.*);

    always #10 clk = ~clk;

    // Discriminator fires while the threshold DAC is at or above the threshold
    always @(posedge clk) begin
        trigger_n <= !(rst_n && int'(dac0) >= thr_cur);
    end

    task automatic check_val(input string name, input logic [MASK_W-1:0] got,
                             input logic [MASK_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Each injected channel opens its three discriminators
    function automatic logic [MASK_W-1:0] expected_mask(input logic [CHN_N-1:0] chn);
        logic [MASK_W-1:0] m;
        m = '0;
        for (int i = 0; i < CHN_N; i++) begin
            if (chn[i]) begin
                m[3*i +: 3] = 3'b111;
            end
        end
        return m;
    endfunction

    // Parameter load monitor during sweeps
    always @(negedge clk) begin
        if (rst_n && sweep_on && sc_param_load) begin
            load_cnt++;
            check_val("dac0", dac0, exp_code);
            check_val("dac1", dac1, exp_code);
            check_val("dac2", dac2, exp_code);
            check_val("ctest_chn", ctest_chn, chn_cur);
            check_val("discri_mask", discri_mask, expected_mask(chn_cur));
            check_val("usb_start_stop", usb_start_stop, 1'b1);
            exp_code++;
        end
    end

    ////////////////////////////////////////////////////////////
    // AXI4-Lite host
    ////////////////////////////////////////////////////////////
    task automatic axi_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        wstrb <= strb;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        do @(negedge clk); while (!awready);
        check_val("wready", wready, 1'b1);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        do @(negedge clk); while (!bvalid);
        check_val("bresp", bresp, 2'b00);
    endtask

    task automatic axi_read(input logic [AXIL_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!rvalid);
        check_val("rresp", rresp, 2'b00);
        data = rdata;
    endtask

    // Pop one word off the FIFO and compare with the model
    task automatic pop_and_check();
        logic [USB_DATA_W-1:0] exp;
        do @(negedge clk); while (fifo_empty);
        exp = exp_q.pop_front();
        check_val("fifo_dout", fifo_dout, exp);
        @(posedge clk);
        fifo_rd_en <= 1'b1;
        @(posedge clk);
        fifo_rd_en <= 1'b0;
    endtask

    task automatic send_hits(input int n, input bit keep_first);
        logic [USB_DATA_W-1:0] v;
        for (int i = 0; i < n; i++) begin
            v = USB_DATA_W'($urandom);
            @(posedge clk);
            hit_valid <= 1'b1;
            hit_data <= v;
            if (!keep_first || i < FIFO_DEPTH) begin
                exp_q.push_back(v);
            end
        end
        @(posedge clk);
        hit_valid <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Table rows
    ////////////////////////////////////////////////////////////
    task automatic run_acq(input row_t r, inout int drops);
        logic [31:0] dacs;
        logic [31:0] rd;
        int n;
        dacs = $urandom & 32'h3FFF_FFFF;
        axi_write(REG_CHN_LO, r.chn_lo, 4'hF);
        axi_write(REG_CHN_HI, r.chn_hi, 4'hF);
        axi_write(REG_USB_DAC, dacs, 4'hF);
        axi_write(REG_CTRL, 32'h1, 4'hF);
        @(negedge clk);
        check_val("dac0", dac0, dacs[9:0]);
        check_val("dac1", dac1, dacs[19:10]);
        check_val("dac2", dac2, dacs[29:20]);
        check_val("ctest_chn", ctest_chn, {r.chn_hi, r.chn_lo});
        check_val("discri_mask", discri_mask, {MASK_W{1'b1}});
        check_val("usb_start_stop", usb_start_stop, 1'b1);
        if (r.stall) begin
            send_hits(r.hits, 1'b1);
            drops += r.hits - FIFO_DEPTH;
            n = FIFO_DEPTH;
            repeat (n) pop_and_check();
        end else begin
            n = r.hits;
            fork
                send_hits(r.hits, 1'b0);
                repeat (n) pop_and_check();
            join
        end
        @(negedge clk);
        check_val("fifo_empty", fifo_empty, 1'b1);
        axi_read(REG_STATUS, rd);
        check_val("drop_cnt", rd[31:16], drops);
    endtask

    task automatic run_scurve(input row_t r);
        logic [31:0] rd;
        int n;
        int polls;
        n = r.dac_last - r.dac_first + 1;
        axi_write(REG_CTRL, 32'h0, 4'hF);
        axi_write(REG_DAC_FIRST, r.dac_first, 4'hF);
        axi_write(REG_DAC_LAST, r.dac_last, 4'hF);
        axi_write(REG_CHN_LO, r.chn_lo, 4'hF);
        axi_write(REG_CHN_HI, r.chn_hi, 4'hF);
        @(negedge clk);
        check_val("usb_start_stop", usb_start_stop, 1'b0);
        thr_cur = r.thr;
        chn_cur = {r.chn_hi, r.chn_lo};
        exp_code = r.dac_first;
        load_cnt = 0;
        // Code word followed by a full window or zero counts
        for (int c = r.dac_first; c <= r.dac_last; c++) begin
            exp_q.push_back(USB_DATA_W'(c));
            exp_q.push_back(c >= r.thr ? USB_DATA_W'(WINDOW_CYCLES) : '0);
        end
        sweep_on = 1;
        axi_write(REG_CTRL, 32'h2, 4'h1);
        if (r.stall) begin
            repeat (STALL_CYCLES) @(posedge clk);
        end
        repeat (2 * n) pop_and_check();
        polls = 0;
        do begin
            axi_read(REG_STATUS, rd);
            polls++;
        end while (!rd[1] && polls < 100);
        check_val("status_done", rd[1], 1'b1);
        check_val("load_count", load_cnt, n);
        sweep_on = 0;
        @(negedge clk);
        check_val("usb_start_stop", usb_start_stop, 1'b0);
        check_val("fifo_empty", fifo_empty, 1'b1);
    endtask

    task automatic check_registers();
        logic [31:0] rd;
        axi_write(REG_DAC_FIRST, 32'hFFFF, 4'hF);
        axi_read(REG_DAC_FIRST, rd);
        check_val("reg_dac_first", rd, 32'h3FF);
        axi_write(REG_CHN_LO, 32'hAABB_CCDD, 4'hF);
        axi_write(REG_CHN_LO, 32'h1122_3344, 4'b0101);
        axi_read(REG_CHN_LO, rd);
        check_val("reg_chn_lo", rd, 32'hAA22_CC44);
        axi_write(REG_USB_DAC, 32'h1234_5678, 4'hF);
        axi_read(REG_USB_DAC, rd);
        check_val("reg_usb_dac", rd, 32'h1234_5678);
        // Start bit never reads back
        axi_write(REG_CTRL, 32'h3, 4'hF);
        axi_read(REG_CTRL, rd);
        check_val("reg_ctrl", rd, 32'h1);
        axi_write(REG_CTRL, 32'h0, 4'hF);
        @(posedge clk);
        pktend_n <= 1'b0;
        repeat (3) @(posedge clk);
        axi_read(REG_STATUS, rd);
        check_val("transmit_done", rd[2], 1'b1);
        @(posedge clk);
        pktend_n <= 1'b1;
        repeat (3) @(posedge clk);
        axi_read(REG_STATUS, rd);
        check_val("transmit_done", rd[2], 1'b0);
    endtask

    initial begin
        int drops;
        void'($urandom(11));
        rows[0] = '{1'b0, 100, 107, 32'h0000_0005, 32'h8000_0000, 104, 0, 0};
        rows[1] = '{1'b1, 0, 0, 32'h0000_1234, 32'h0000_F0F0, 0, 20, 0};
        rows[2] = '{1'b0, 200, 219, 32'h0000_0001, 32'h0000_0000, 210, 0, 1};
        rows[3] = '{1'b1, 0, 0, 32'hFFFF_0000, 32'h0000_00FF, 0, 40, 1};
        rst_n = 1'b0;
        awaddr = '0;
        araddr = '0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        arvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b1;
        rready = 1'b1;
        hit_data = '0;
        hit_valid = 1'b0;
        trigger_n = 1'b1;
        pktend_n = 1'b1;
        fifo_rd_en = 1'b0;
        drops = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_registers();
        for (int i = 0; i < N_ROWS; i++) begin
            if (rows[i].mode) begin
                run_acq(rows[i], drops);
            end else begin
                run_scurve(rows[i]);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run length from the table plus margin
    initial begin
        longint limit;
        #1;
        limit = 5000;
        for (int i = 0; i < N_ROWS; i++) begin
            limit += (rows[i].dac_last - rows[i].dac_first + 1) * CODE_CYCLES;
            limit += rows[i].hits * 4;
            limit += rows[i].stall ? STALL_CYCLES : 0;
        end
        #(limit * 20);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== microroc_daq_top.sv ====
`timescale 1ns/1ps

module microroc_daq_top import microroc_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [AXIL_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [AXIL_DATA_W-1:0]   wdata,
    input  logic [AXIL_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [AXIL_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic [USB_DATA_W-1:0]    hit_data,
    input  logic                     hit_valid,
    input  logic                     trigger_n,
    input  logic                     pktend_n,
    input  logic                     fifo_rd_en,
    output logic [USB_DATA_W-1:0]    fifo_dout,
    output logic                     fifo_empty,
    output logic                     usb_start_stop,
    output logic [CHN_N-1:0]         ctest_chn,
    output logic [DAC_W-1:0]         dac0,
    output logic [DAC_W-1:0]         dac1,
    output logic [DAC_W-1:0]         dac2,
    output logic [MASK_W-1:0]        discri_mask,
    output logic                     sc_param_load
);

    daq_mode_e mode;
    logic start;
    logic busy;
    logic done;
    logic win_start;
    logic win_active;
    logic [DAC_W-1:0] dac_first;
    logic [DAC_W-1:0] dac_last;
    logic [CHN_N-1:0] host_chn;
    logic [DAC_W-1:0] usb_dac0;
    logic [DAC_W-1:0] usb_dac1;
    logic [DAC_W-1:0] usb_dac2;
    logic [CNT_W-1:0] drop_cnt;
    logic [CNT_W-1:0] trig_count;

    usb_wr_if acq_usb ();
    usb_wr_if scurve_usb ();
    usb_wr_if fifo_usb ();
    sc_param_if acq_sc ();
    sc_param_if scurve_sc ();

    sc_reg_bank i_reg_bank (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .mode, .start, .dac_first, .dac_last,
        .ctest_chn(host_chn),
        .usb_dac0, .usb_dac1, .usb_dac2,
        .busy, .done, .pktend_n, .drop_cnt
    );

    ////////////////////////////////////////////////////////////
    // Acquisition side parameters from the host registers
    ////////////////////////////////////////////////////////////
    assign acq_sc.ctest_chn = host_chn;
    assign acq_sc.dac0 = usb_dac0;
    assign acq_sc.dac1 = usb_dac1;
    assign acq_sc.dac2 = usb_dac2;
    // Every discriminator open during acquisition
    assign acq_sc.mask = '1;
    // Start loads host values in acquisition, sweeps otherwise
    assign acq_sc.load = start && (mode == MODE_ACQ);

    scurve_ctrl i_scurve_ctrl (
        .clk, .rst_n,
        .start(start && (mode == MODE_SCURVE)),
        .dac_first, .dac_last,
        .ctest_chn(host_chn),
        .trig_count, .busy, .done, .win_start, .win_active,
        .usb(scurve_usb),
        .sc(scurve_sc)
    );

    trig_counter i_trig_counter (
        .clk, .rst_n, .trigger_n, .win_start, .win_active,
        .count(trig_count)
    );

    acq_packer i_acq_packer (
        .clk, .rst_n, .mode, .hit_data, .hit_valid, .drop_cnt,
        .usb(acq_usb)
    );

    acq_scurve_switch i_switch (
        .mode,
        .acq_usb(acq_usb),
        .scurve_usb(scurve_usb),
        .usb_out(fifo_usb),
        .acq_sc(acq_sc),
        .scurve_sc(scurve_sc),
        .ctest_chn, .dac0, .dac1, .dac2, .discri_mask, .sc_param_load
    );

    usb_data_fifo i_usb_fifo (
        .clk, .rst_n,
        .wr(fifo_usb),
        .rd_en(fifo_rd_en),
        .dout(fifo_dout),
        .empty(fifo_empty)
    );

    // Selected source's request goes out to the USB side
    assign usb_start_stop = fifo_usb.start_stop;

endmodule

// ==== usb_data_fifo.sv ====
`timescale 1ns/1ps

module usb_data_fifo import microroc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    usb_wr_if.sink                wr,
    input  logic                  rd_en,
    output logic [USB_DATA_W-1:0] dout,
    output logic                  empty
);

    logic [USB_DATA_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0] count;
    logic do_wr;
    logic do_rd;

    assign do_wr = wr.wr_en && !wr.full;
    assign do_rd = rd_en && !empty;
    assign empty = (count == '0);
    assign wr.full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    // Head word shown without a read request
    assign dout = mem[rd_ptr];

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (FIFO_AW + 1)'(do_wr) - (FIFO_AW + 1)'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr.din;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr.wr_en |-> !wr.full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> !empty);

endmodule

// ==== acq_scurve_switch.sv ====
`timescale 1ns/1ps

module acq_scurve_switch import microroc_pkg::*; (
    input  daq_mode_e         mode,
    usb_wr_if.sel             acq_usb,
    usb_wr_if.sel             scurve_usb,
    usb_wr_if.src             usb_out,
    sc_param_if.dst           acq_sc,
    sc_param_if.dst           scurve_sc,
    output logic [CHN_N-1:0]  ctest_chn,
    output logic [DAC_W-1:0]  dac0,
    output logic [DAC_W-1:0]  dac1,
    output logic [DAC_W-1:0]  dac2,
    output logic [MASK_W-1:0] discri_mask,
    output logic              sc_param_load
);

    logic acq_sel;

    assign acq_sel = (mode == MODE_ACQ);

    ////////////////////////////////////////////////////////////
    // USB FIFO write port
    ////////////////////////////////////////////////////////////
    assign usb_out.din = acq_sel ? acq_usb.din : scurve_usb.din;
    assign usb_out.wr_en = acq_sel ? acq_usb.wr_en : scurve_usb.wr_en;
    assign usb_out.start_stop = acq_sel ? acq_usb.start_stop : scurve_usb.start_stop;
    // Idle source sees full and holds off
    assign acq_usb.full = acq_sel ? usb_out.full : 1'b1;
    assign scurve_usb.full = acq_sel ? 1'b1 : usb_out.full;

    ////////////////////////////////////////////////////////////
    // Chip slow-control parameters
    ////////////////////////////////////////////////////////////
    assign ctest_chn = acq_sel ? acq_sc.ctest_chn : scurve_sc.ctest_chn;
    assign dac0 = acq_sel ? acq_sc.dac0 : scurve_sc.dac0;
    assign dac1 = acq_sel ? acq_sc.dac1 : scurve_sc.dac1;
    assign dac2 = acq_sel ? acq_sc.dac2 : scurve_sc.dac2;
    assign discri_mask = acq_sel ? acq_sc.mask : scurve_sc.mask;
    assign sc_param_load = acq_sel ? acq_sc.load : scurve_sc.load;

endmodule

// ==== acq_packer.sv ====
`timescale 1ns/1ps

module acq_packer import microroc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  daq_mode_e             mode,
    input  logic [USB_DATA_W-1:0] hit_data,
    input  logic                  hit_valid,
    output logic [CNT_W-1:0]      drop_cnt,
    usb_wr_if.src                 usb
);

    logic acq_on;
    logic drop;

    assign acq_on = (mode == MODE_ACQ);

    // Hit goes in on the edge it is sampled
    assign usb.wr_en = hit_valid && acq_on && !usb.full;
    assign usb.din = hit_data;
    assign usb.start_stop = acq_on;

    // Lost to a full FIFO or the wrong mode
    assign drop = hit_valid && !usb.wr_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drop_cnt <= '0;
        end else if (drop && drop_cnt != '1) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end

endmodule

// ==== trig_counter.sv ====
`timescale 1ns/1ps

module trig_counter import microroc_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             trigger_n,
    input  logic             win_start,
    input  logic             win_active,
    output logic [CNT_W-1:0] count
);

    logic [1:0] trig_sync;

    // Two-flop synchronizer with idle level high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trig_sync <= 2'b11;
        end else begin
            trig_sync <= {trig_sync[0], trigger_n};
        end
    end

    // Cycles with trigger low inside the window
    always_ff @(posedge clk) begin
        if (!rst_n || win_start) begin
            count <= '0;
        end else if (win_active && !trig_sync[1] && count != '1) begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== scurve_ctrl.sv ====
`timescale 1ns/1ps

module scurve_ctrl import microroc_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [DAC_W-1:0] dac_first,
    input  logic [DAC_W-1:0] dac_last,
    input  logic [CHN_N-1:0] ctest_chn,
    input  logic [CNT_W-1:0] trig_count,
    output logic             busy,
    output logic             done,
    output logic             win_start,
    output logic             win_active,
    usb_wr_if.src            usb,
    sc_param_if.src          sc
);

    scurve_state_e state;
    logic [DAC_W-1:0] code;
    logic [TMR_W-1:0] tmr;
    logic [CHN_N-1:0] chn_q;
    logic wr_state;

    ////////////////////////////////////////////////////////////
    // Sweep sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            code <= '0;
            tmr <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        code <= dac_first;
                        busy <= 1'b1;
                        done <= 1'b0;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    tmr <= '0;
                    state <= ST_SETTLE;
                end
                // Let the DAC and discriminators settle
                ST_SETTLE: begin
                    if (tmr == TMR_W'(SETTLE_CYCLES - 1)) begin
                        tmr <= '0;
                        state <= ST_COUNT;
                    end else begin
                        tmr <= tmr + 1'b1;
                    end
                end
                ST_COUNT: begin
                    if (tmr == TMR_W'(WINDOW_CYCLES - 1)) begin
                        state <= ST_WR_CODE;
                    end else begin
                        tmr <= tmr + 1'b1;
                    end
                end
                // Both words stall on a full FIFO
                ST_WR_CODE: begin
                    if (!usb.full) begin
                        state <= ST_WR_CNT;
                    end
                end
                ST_WR_CNT: begin
                    if (!usb.full) begin
                        state <= ST_NEXT;
                    end
                end
                ST_NEXT: begin
                    if (code >= dac_last) begin
                        state <= ST_DONE;
                    end else begin
                        code <= code + 1'b1;
                        state <= ST_LOAD;
                    end
                end
                default: begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Channel set frozen for the whole sweep
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            chn_q <= ctest_chn;
        end
    end

    assign win_start = (state == ST_LOAD);
    assign win_active = (state == ST_COUNT);

    ////////////////////////////////////////////////////////////
    // Slow-control and FIFO outputs
    ////////////////////////////////////////////////////////////
    assign sc.ctest_chn = chn_q;
    assign sc.dac0 = code;
    assign sc.dac1 = code;
    assign sc.dac2 = code;
    assign sc.load = (state == ST_LOAD);

    // Unmask all three discriminators of an injected channel
    always_comb begin
        for (int i = 0; i < CHN_N; i++) begin
            sc.mask[3*i +: 3] = {3{chn_q[i]}};
        end
    end

    assign wr_state = (state == ST_WR_CODE) || (state == ST_WR_CNT);
    assign usb.wr_en = wr_state && !usb.full;
    // Code word first and the count after it
    assign usb.din = (state == ST_WR_CNT) ? USB_DATA_W'(trig_count) : USB_DATA_W'(code);
    assign usb.start_stop = busy;

    // A word held off by a full FIFO stays on din until taken
    a_hold_on_full: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_state && usb.full) |=> (wr_state && $stable(usb.din)));

endmodule

// ==== sc_reg_bank.sv ====
`timescale 1ns/1ps

module sc_reg_bank import microroc_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [AXIL_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [AXIL_DATA_W-1:0]   wdata,
    input  logic [AXIL_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [AXIL_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output daq_mode_e                mode,
    output logic                     start,
    output logic [DAC_W-1:0]         dac_first,
    output logic [DAC_W-1:0]         dac_last,
    output logic [CHN_N-1:0]         ctest_chn,
    output logic [DAC_W-1:0]         usb_dac0,
    output logic [DAC_W-1:0]         usb_dac1,
    output logic [DAC_W-1:0]         usb_dac2,
    input  logic                     busy,
    input  logic                     done,
    input  logic                     pktend_n,
    input  logic [CNT_W-1:0]         drop_cnt
);

    logic wr_fire;
    logic rd_fire;
    logic tx_done;
    logic [AXIL_DATA_W-1:0] wr_val;

    // Current register contents
    // Start always reads zero
    function automatic logic [AXIL_DATA_W-1:0] reg_read(input logic [AXIL_ADDR_W-1:0] addr);
        case (addr)
            REG_CTRL:      return AXIL_DATA_W'(mode);
            REG_DAC_FIRST: return AXIL_DATA_W'(dac_first);
            REG_DAC_LAST:  return AXIL_DATA_W'(dac_last);
            REG_CHN_LO:    return ctest_chn[31:0];
            REG_CHN_HI:    return ctest_chn[63:32];
            REG_USB_DAC:   return {2'b00, usb_dac2, usb_dac1, usb_dac0};
            REG_STATUS:    return {drop_cnt, 13'd0, tx_done, done, busy};
            default:       return '0;
        endcase
    endfunction

    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;
    assign wready = awready;
    // Always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // Byte lanes merged over the old value
    always_comb begin
        wr_val = reg_read(awaddr);
        for (int b = 0; b < AXIL_DATA_W / 8; b++) begin
            if (wstrb[b]) begin
                wr_val[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            bvalid <= 1'b0;
            start <= 1'b0;
            mode <= MODE_SCURVE;
            dac_first <= '0;
            dac_last <= '0;
            ctest_chn <= '0;
            usb_dac0 <= '0;
            usb_dac1 <= '0;
            usb_dac2 <= '0;
        end else begin
            // AW and W taken together for one cycle
            awready <= awvalid && wvalid && !awready && !bvalid;
            start <= 1'b0;
            if (wr_fire) begin
                bvalid <= 1'b1;
                case (awaddr)
                    REG_CTRL: begin
                        mode <= daq_mode_e'(wr_val[0]);
                        start <= wr_val[1] && wstrb[0];
                    end
                    REG_DAC_FIRST: dac_first <= wr_val[DAC_W-1:0];
                    REG_DAC_LAST:  dac_last <= wr_val[DAC_W-1:0];
                    REG_CHN_LO:    ctest_chn[31:0] <= wr_val;
                    REG_CHN_HI:    ctest_chn[63:32] <= wr_val;
                    REG_USB_DAC: begin
                        usb_dac0 <= wr_val[9:0];
                        usb_dac1 <= wr_val[19:10];
                        usb_dac2 <= wr_val[29:20];
                    end
                    default: ;
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read channel and status
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            // Packet end seen by the USB side
            tx_done <= ~pktend_n;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= reg_read(araddr);
        end
    end

    // No new write is taken while a response is still pending
    a_no_write_during_resp: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> !awready);

endmodule

// ==== microroc_ifs.sv ====
`timescale 1ns/1ps

// Write side of the USB data FIFO
interface usb_wr_if import microroc_pkg::*; ();
    logic [USB_DATA_W-1:0] din;
    logic wr_en;
    logic full;
    // Start/stop request toward the USB side
    logic start_stop;

    modport src (output din, output wr_en, output start_stop, input full);
    // Switch side facing one of the two sources
    modport sel (input din, input wr_en, input start_stop, output full);
    modport sink (input din, input wr_en, output full);
endinterface

// Slow-control parameter set for the chip
interface sc_param_if import microroc_pkg::*; ();
    logic [CHN_N-1:0] ctest_chn;
    logic [DAC_W-1:0] dac0;
    logic [DAC_W-1:0] dac1;
    logic [DAC_W-1:0] dac2;
    logic [MASK_W-1:0] mask;
    // One-cycle strobe that marks the values valid
    logic load;

    modport src (
        output ctest_chn, output dac0, output dac1, output dac2,
        output mask, output load
    );
    modport dst (
        input ctest_chn, input dac0, input dac1, input dac2,
        input mask, input load
    );
endinterface

// ==== microroc_pkg.sv ====
package microroc_pkg;

    ////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////
    localparam int USB_DATA_W = 16;
    localparam int DAC_W = 10;
    localparam int CHN_N = 64;
    // Three discriminators per channel
    localparam int MASK_W = 3 * CHN_N;
    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // S-curve timing, in clock cycles
    localparam int SETTLE_CYCLES = 16;
    localparam int WINDOW_CYCLES = 64;
    // Timer sized for the longer of the two phases
    localparam int TMR_W = $clog2(WINDOW_CYCLES);
    localparam int CNT_W = 16;

    ////////////////////////////////////////////////////////////
    // Host register map
    ////////////////////////////////////////////////////////////
    localparam int AXIL_ADDR_W = 6;
    localparam int AXIL_DATA_W = 32;
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL = 6'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_DAC_FIRST = 6'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_DAC_LAST = 6'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_CHN_LO = 6'h0C;
    localparam logic [AXIL_ADDR_W-1:0] REG_CHN_HI = 6'h10;
    localparam logic [AXIL_ADDR_W-1:0] REG_USB_DAC = 6'h14;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 6'h18;

    // Mode 1 selects acquisition
    typedef enum logic {
        MODE_SCURVE = 1'b0,
        MODE_ACQ = 1'b1
    } daq_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SETTLE,
        ST_COUNT,
        ST_WR_CODE,
        ST_WR_CNT,
        ST_NEXT,
        ST_DONE
    } scurve_state_e;

endpackage
